// ==== flist.f ====
+incdir+rtl
rtl/fetch_pkg.sv
rtl/fetch_pc_sel.sv
rtl/fetch_prefetcher.sv
rtl/fetch_align_fifo.sv
rtl/fetch_c_decoder.sv
rtl/fetch_stage.sv
sim/tb_fetch_stage.sv

// ==== rtl/fetch_align_fifo.sv ====
// Word FIFO with halfword read pointer, yields aligned 16/32-bit instructions
`timescale 1ns/1ps
`include "fetch_settings.svh"

module fetch_align_fifo (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    flush_i,
  input  logic [`FETCH_XLEN-1:0]  redirect_addr_i,
  input  logic                    push_i,
  input  fetch_pkg::mem_resp_t    push_word_i,
  input  logic                    instr_pop_i,
  output logic                    instr_avail_o,
  output fetch_pkg::instr_word_u  instr_o,
  output logic [`FETCH_XLEN-1:0]  instr_pc_o,
  output logic                    instr_err_o,
  output logic                    credit_return_o
);

  localparam int XLEN  = `FETCH_XLEN;
  localparam int DEPTH = `FETCH_FIFO_WORDS;
  localparam int IDX_W = $clog2(DEPTH);
  localparam int CNT_W = `FETCH_CNT_W;

  fetch_pkg::mem_resp_t   ring_q [DEPTH];
  logic [IDX_W-1:0]       wr_ptr_q;
  logic [IDX_W-1:0]       rd_ptr_q;
  logic [IDX_W-1:0]       rd_next;
  logic [CNT_W-1:0]       count_q;    // Words held
  logic                   half_q;     // Read pointer on upper halfword
  logic [XLEN-1:0]        pc_q;
  fetch_pkg::instr_word_u word0;
  fetch_pkg::instr_word_u word1;
  logic [15:0]            first_half;
  logic                   is_32;
  logic                   straddle;   // Spans two ring entries
  logic                   pop;
  logic                   free_word;

  assign rd_next = rd_ptr_q + 1'b1;

  ////////////////////
  // Instruction assembly
  ////////////////////

  always_comb begin
    word0.word  = ring_q[rd_ptr_q].rdata;
    word1.word  = ring_q[rd_next].rdata;
    first_half  = half_q ? word0.half.hi : word0.half.lo;
    is_32       = (first_half[1:0] == 2'b11);  // RVC quadrant 3 is a full word
    straddle    = half_q && is_32;
    instr_o.word = half_q ? {word1.half.lo, word0.half.hi} : word0.word;
    instr_err_o  = ring_q[rd_ptr_q].err || (straddle && ring_q[rd_next].err);
  end

  // Straddling needs the following word too
  assign instr_avail_o = (count_q != '0) && (!straddle || (count_q > CNT_W'(1)));
  assign instr_pc_o    = pc_q;

  assign pop       = instr_pop_i && instr_avail_o;
  // Leaving a word whenever the read ends at or past its top halfword
  assign free_word = pop && (half_q || is_32);
  assign credit_return_o = free_word && !flush_i;  // Prefetcher reloads credits on flush

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      half_q   <= 1'b0;
      pc_q     <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      half_q   <= redirect_addr_i[1];   // First word is fetched aligned
      pc_q     <= redirect_addr_i;
    end else begin
      if (push_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (free_word) begin
        rd_ptr_q <= rd_next;
      end
      if (pop) begin
        half_q <= half_q ^ ~is_32;  // 16-bit step flips, 32-bit keeps
        pc_q   <= pc_q + (is_32 ? XLEN'(4) : XLEN'(2));
      end
      count_q <= count_q + CNT_W'(push_i) - CNT_W'(free_word);
    end
  end

  // Ring storage
  always_ff @(posedge clk) begin
    if (push_i) begin
      ring_q[wr_ptr_q] <= push_word_i;
    end
  end

  // Credits from the prefetcher must keep a slot free for each response
  a_no_push_when_full: assert property (
    @(posedge clk) disable iff (!rst_n)
    (push_i && !flush_i) |-> (count_q != CNT_W'(DEPTH))
  );

endmodule

// ==== rtl/fetch_c_decoder.sv ====
// RVC expander for C.ADDI, C.LI, C.MV, C.ADD and C.J, others flagged illegal
`timescale 1ns/1ps

module fetch_c_decoder (
  input  fetch_pkg::instr_word_u instr_i,
  output logic [31:0]            instr_o,
  output logic                   is_compressed_o,
  output logic                   illegal_c_o
);

  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;

  logic [15:0] c;
  logic [11:0] imm6;   // CI immediate, sign extended
  logic [4:0]  rd;
  logic [4:0]  rs2;

  assign c    = instr_i.half.lo;
  assign rd   = c[11:7];
  assign rs2  = c[6:2];
  assign imm6 = {{6{c[12]}}, c[12], c[6:2]};

  assign is_compressed_o = (c[1:0] != 2'b11);

  always_comb begin
    instr_o     = instr_i.word;   // Full-width pass through
    illegal_c_o = 1'b0;
    if (is_compressed_o) begin
      instr_o     = {16'h0000, c};  // Raw halfword unless expanded
      illegal_c_o = 1'b1;
      unique case ({c[15:13], c[1:0]})
        // C.ADDI: addi rd, rd, imm
        5'b000_01: begin
          instr_o     = {imm6, rd, 3'b000, rd, OPC_OP_IMM};
          illegal_c_o = 1'b0;
        end
        // C.LI: addi rd, x0, imm
        5'b010_01: begin
          instr_o     = {imm6, 5'd0, 3'b000, rd, OPC_OP_IMM};
          illegal_c_o = 1'b0;
        end
        // C.J: jal x0, offset
        5'b101_01: begin
          instr_o     = {c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3],
                         c[12], {8{c[12]}}, 5'd0, OPC_JAL};
          illegal_c_o = 1'b0;
        end
        5'b100_10: begin
          if (rs2 != 5'd0) begin
            illegal_c_o = 1'b0;
            if (c[12]) begin
              instr_o = {7'b0, rs2, rd, 3'b000, rd, OPC_OP};      // C.ADD
            end else begin
              instr_o = {7'b0, rs2, 5'd0, 3'b000, rd, OPC_OP};    // C.MV
            end
          end
          // rs2 == 0 is C.JR/C.JALR/C.EBREAK, not expanded
        end
        default: begin
          instr_o     = {16'h0000, c};
          illegal_c_o = 1'b1;
        end
      endcase
    end
  end

endmodule

// ==== rtl/fetch_pc_sel.sv ====
// Redirect address selection and mtvec init pulse on boot
`timescale 1ns/1ps
`include "fetch_settings.svh"

module fetch_pc_sel (
  input  fetch_pkg::ctrl_fsm_t        ctrl_fsm_i,
  input  logic [`FETCH_XLEN-1:0]      boot_addr_i,
  input  logic [`FETCH_XLEN-1:0]      jump_target_i,
  input  logic [`FETCH_XLEN-1:0]      branch_target_i,
  input  logic [`FETCH_XLEN-1:0]      mepc_i,
  input  logic [`FETCH_XLEN-1:0]      dpc_i,
  input  logic [`FETCH_XLEN-1:0]      dm_halt_addr_i,
  input  logic [`FETCH_MTVEC_W-1:0]   mtvec_addr_i,
  output logic [`FETCH_XLEN-1:0]      redirect_addr_o,
  output logic                        csr_mtvec_init_o
);

  logic [`FETCH_XLEN-1:0] target;

  always_comb begin
    target = {boot_addr_i[`FETCH_XLEN-1:2], 2'b00};
    unique case (ctrl_fsm_i.pc_mux)
      fetch_pkg::BOOT:     target = {boot_addr_i[`FETCH_XLEN-1:2], 2'b00};
      fetch_pkg::JUMP:     target = jump_target_i;
      fetch_pkg::BRANCH:   target = branch_target_i;
      fetch_pkg::MRET:     target = mepc_i;   // Back from trap
      fetch_pkg::DRET:     target = dpc_i;    // Back from debug
      fetch_pkg::TRAP_EXC: target = {mtvec_addr_i, 7'h00};
      // Base plus irq_id * 4
      fetch_pkg::TRAP_IRQ: target = {mtvec_addr_i, ctrl_fsm_i.irq_id, 2'b00};
      fetch_pkg::TRAP_DBG: target = {dm_halt_addr_i[`FETCH_XLEN-1:2], 2'b00};
      default:             target = {boot_addr_i[`FETCH_XLEN-1:2], 2'b00};
    endcase
  end

  // Halfword granularity only
  assign redirect_addr_o = {target[`FETCH_XLEN-1:1], 1'b0};

  // CSR file loads mtvec from boot state
  assign csr_mtvec_init_o = ctrl_fsm_i.pc_set && (ctrl_fsm_i.pc_mux == fetch_pkg::BOOT);

endmodule

// ==== rtl/fetch_pkg.sv ====
// Fetch stage types: redirect select, control, memory port, instruction word, IF/ID
`include "fetch_settings.svh"

package fetch_pkg;

  ////////////////////
  // Redirect control
  ////////////////////

  // Next fetch address source
  typedef enum logic [2:0] {
    BOOT,
    JUMP,
    BRANCH,
    MRET,
    DRET,
    TRAP_EXC,   // Non-vectored, mtvec base
    TRAP_IRQ,   // Vectored interrupt
    TRAP_DBG    // Debug halt entry
  } pc_mux_e;

  typedef struct packed {
    logic                       pc_set;   // Redirect strobe, flushes the prefetcher
    pc_mux_e                    pc_mux;
    logic [`FETCH_IRQ_ID_W-1:0] irq_id;
    logic                       kill_if;  // Drop instructions in IF
    logic                       halt_if;  // Freeze IF
  } ctrl_fsm_t;

  ////////////////////
  // Memory port
  ////////////////////

  typedef struct packed {
    logic [`FETCH_XLEN-1:0] addr;   // Always word aligned
  } mem_req_t;

  typedef struct packed {
    logic [`FETCH_XLEN-1:0] rdata;
    logic                   err;    // Bus error on this word
  } mem_resp_t;

  // Fetch word viewed whole or as two halfwords
  typedef struct packed {
    logic [15:0] hi;
    logic [15:0] lo;
  } half_pair_t;

  typedef union packed {
    logic [31:0] word;
    half_pair_t  half;
  } instr_word_u;

  // IF/ID pipeline register
  typedef struct packed {
    logic                   instr_valid;
    logic [31:0]            instr;             // Expanded encoding
    logic [`FETCH_XLEN-1:0] pc;
    logic [15:0]            compressed_instr;  // Raw low halfword
    logic                   is_compressed;
    logic                   illegal_c;
    logic                   bus_err;
  } if_id_pipe_t;

endpackage

// ==== rtl/fetch_prefetcher.sv ====
// Credit-limited word prefetcher with stale response discard after flush
`timescale 1ns/1ps
`include "fetch_settings.svh"

module fetch_prefetcher (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   flush_i,
  input  logic [`FETCH_XLEN-1:0] redirect_addr_i,
  output logic                   mem_req_valid_o,
  input  logic                   mem_req_ready_i,
  output fetch_pkg::mem_req_t    mem_req_o,
  input  logic                   mem_resp_valid_i,
  input  fetch_pkg::mem_resp_t   mem_resp_i,
  input  logic                   credit_return_i,
  output logic                   push_o,
  output fetch_pkg::mem_resp_t   push_word_o,
  output logic                   busy_o
);

  localparam int XLEN  = `FETCH_XLEN;
  localparam int CNT_W = `FETCH_CNT_W;
  localparam logic [CNT_W-1:0] FULL_CREDITS = CNT_W'(`FETCH_FIFO_WORDS);

  logic [XLEN-1:2]  next_word_q;     // Word address of next request
  logic             active_q;        // Set by first redirect
  logic [CNT_W-1:0] credits_q;       // Free FIFO slots not yet claimed
  logic [CNT_W-1:0] outstanding_q;   // Issued, no response yet
  logic [CNT_W-1:0] discard_q;       // Responses still owed to a flushed stream
  logic [CNT_W-1:0] out_after_resp;
  logic             req_fire;
  logic             resp_stale;

  ////////////////////
  // Request side
  ////////////////////

  assign mem_req_valid_o = active_q && (credits_q != '0) && !flush_i;
  assign mem_req_o.addr  = {next_word_q, 2'b00};
  assign req_fire        = mem_req_valid_o && mem_req_ready_i;

  ////////////////////
  // Response side
  ////////////////////

  assign resp_stale  = mem_resp_valid_i && (discard_q != '0);
  assign push_o      = mem_resp_valid_i && !resp_stale && !flush_i;  // FIFO clears on flush
  assign push_word_o = mem_resp_i;
  assign busy_o      = (outstanding_q != '0);

  assign out_after_resp = outstanding_q - CNT_W'(mem_resp_valid_i);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      active_q      <= 1'b0;
      next_word_q   <= '0;
      credits_q     <= FULL_CREDITS;
      outstanding_q <= '0;
      discard_q     <= '0;
    end else if (flush_i) begin
      // Everything still in flight belongs to the old stream
      active_q      <= 1'b1;
      next_word_q   <= redirect_addr_i[XLEN-1:2];
      outstanding_q <= out_after_resp;
      discard_q     <= out_after_resp;
      credits_q     <= FULL_CREDITS - out_after_resp;  // Stale slots come back as dropped
    end else begin
      if (req_fire) begin
        next_word_q <= next_word_q + 1'b1;  // Sequential words
      end
      outstanding_q <= out_after_resp + CNT_W'(req_fire);
      discard_q     <= discard_q - CNT_W'(resp_stale);
      credits_q     <= credits_q - CNT_W'(req_fire)
                     + CNT_W'(credit_return_i) + CNT_W'(resp_stale);
    end
  end

  // In-flight words never exceed what the FIFO can absorb
  a_outstanding_bound: assert property (
    @(posedge clk) disable iff (!rst_n) outstanding_q <= FULL_CREDITS
  );

  // Credit accounting with the FIFO keeps a slot for every request
  a_no_req_without_credit: assert property (
    @(posedge clk) disable iff (!rst_n) req_fire |-> (credits_q != '0)
  );

endmodule

// ==== rtl/fetch_settings.svh ====
// Fetch stage settings: widths, FIFO depth, credit and mtvec sizes
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

////////////////////
// Datapath
////////////////////

// Address and fetch word width
`define FETCH_XLEN 32

////////////////////
// Prefetch buffering
////////////////////

// Word FIFO depth, also the credit total of the prefetcher
`define FETCH_FIFO_WORDS 4

// Credit and outstanding counters, must hold FETCH_FIFO_WORDS
`define FETCH_CNT_W 3

////////////////////
// Trap vectors
////////////////////

`define FETCH_MTVEC_W 25   // Significant mtvec base bits
`define FETCH_IRQ_ID_W 5   // Interrupt cause index

`endif

// ==== rtl/fetch_stage.sv ====
// Instruction fetch stage: PC select, prefetch, realign, RVC expand, IF/ID register
`timescale 1ns/1ps
`include "fetch_settings.svh"

module fetch_stage (
  input  logic                      clk,
  input  logic                      rst_n,
  input  fetch_pkg::ctrl_fsm_t      ctrl_fsm_i,
  // Redirect targets
  input  logic [`FETCH_XLEN-1:0]    boot_addr_i,
  input  logic [`FETCH_XLEN-1:0]    jump_target_i,
  input  logic [`FETCH_XLEN-1:0]    branch_target_i,
  input  logic [`FETCH_XLEN-1:0]    mepc_i,
  input  logic [`FETCH_XLEN-1:0]    dpc_i,
  input  logic [`FETCH_XLEN-1:0]    dm_halt_addr_i,
  input  logic [`FETCH_MTVEC_W-1:0] mtvec_addr_i,
  // Instruction memory
  output logic                      mem_req_valid_o,
  input  logic                      mem_req_ready_i,
  output fetch_pkg::mem_req_t       mem_req_o,
  input  logic                      mem_resp_valid_i,
  input  fetch_pkg::mem_resp_t      mem_resp_i,
  // Status and decode handshake
  output logic                      csr_mtvec_init_o,
  output logic                      if_valid_o,
  input  logic                      id_ready_i,
  output logic                      if_busy_o,
  output logic [`FETCH_XLEN-1:0]    pc_if_o,
  output fetch_pkg::if_id_pipe_t    if_id_pipe_o
);

  logic [`FETCH_XLEN-1:0] redirect_addr;
  logic                   push;
  fetch_pkg::mem_resp_t   push_word;
  logic                   credit_return;
  logic                   instr_avail;
  logic                   instr_pop;
  fetch_pkg::instr_word_u fifo_instr;
  logic                   fifo_err;
  logic [31:0]            dec_instr;
  logic                   dec_is_c;
  logic                   dec_illegal;

  fetch_pc_sel pc_sel_i (
    .ctrl_fsm_i       ( ctrl_fsm_i       ),
    .boot_addr_i      ( boot_addr_i      ),
    .jump_target_i    ( jump_target_i    ),
    .branch_target_i  ( branch_target_i  ),
    .mepc_i           ( mepc_i           ),
    .dpc_i            ( dpc_i            ),
    .dm_halt_addr_i   ( dm_halt_addr_i   ),
    .mtvec_addr_i     ( mtvec_addr_i     ),
    .redirect_addr_o  ( redirect_addr    ),
    .csr_mtvec_init_o ( csr_mtvec_init_o )
  );

  fetch_prefetcher prefetcher_i (
    .clk              ( clk               ),
    .rst_n            ( rst_n             ),
    .flush_i          ( ctrl_fsm_i.pc_set ),  // Every redirect restarts the stream
    .redirect_addr_i  ( redirect_addr     ),
    .mem_req_valid_o  ( mem_req_valid_o   ),
    .mem_req_ready_i  ( mem_req_ready_i   ),
    .mem_req_o        ( mem_req_o         ),
    .mem_resp_valid_i ( mem_resp_valid_i  ),
    .mem_resp_i       ( mem_resp_i        ),
    .credit_return_i  ( credit_return     ),
    .push_o           ( push              ),
    .push_word_o      ( push_word         ),
    .busy_o           ( if_busy_o         )
  );

  fetch_align_fifo align_fifo_i (
    .clk             ( clk               ),
    .rst_n           ( rst_n             ),
    .flush_i         ( ctrl_fsm_i.pc_set ),
    .redirect_addr_i ( redirect_addr     ),
    .push_i          ( push              ),
    .push_word_i     ( push_word         ),
    .instr_pop_i     ( instr_pop         ),
    .instr_avail_o   ( instr_avail       ),
    .instr_o         ( fifo_instr        ),
    .instr_pc_o      ( pc_if_o           ),
    .instr_err_o     ( fifo_err          ),
    .credit_return_o ( credit_return     )
  );

  fetch_c_decoder c_decoder_i (
    .instr_i         ( fifo_instr  ),
    .instr_o         ( dec_instr   ),
    .is_compressed_o ( dec_is_c    ),
    .illegal_c_o     ( dec_illegal )
  );

  ////////////////////
  // Handshake
  ////////////////////

  assign if_valid_o = instr_avail && !ctrl_fsm_i.kill_if && !ctrl_fsm_i.halt_if;
  // Kill drains the FIFO regardless of ID
  assign instr_pop  = (if_valid_o && id_ready_i) || (ctrl_fsm_i.kill_if && instr_avail);

  ////////////////////
  // IF/ID register
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      if_id_pipe_o <= '0;
    end else if (if_valid_o && id_ready_i) begin
      if_id_pipe_o.instr_valid      <= 1'b1;
      if_id_pipe_o.instr            <= dec_instr;
      if_id_pipe_o.pc               <= pc_if_o;
      if_id_pipe_o.compressed_instr <= fifo_instr.half.lo;
      if_id_pipe_o.is_compressed    <= dec_is_c;
      if_id_pipe_o.illegal_c        <= dec_illegal;
      if_id_pipe_o.bus_err          <= fifo_err;
    end else if (id_ready_i) begin
      if_id_pipe_o.instr_valid <= 1'b0;   // Bubble into ID
    end
  end

  // ID stall freezes the whole register
  a_if_id_hold: assert property (
    @(posedge clk) disable iff (!rst_n)
    (if_id_pipe_o.instr_valid && !id_ready_i) |=> $stable(if_id_pipe_o)
  );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the fetch stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f flist.f --top-module tb_fetch_stage \
  -Mdir obj_dir -o sim_fetch

# The log decides the result, so a fatal exit must not stop the script here
./obj_dir/sim_fetch > sim.log 2>&1 || true
cat sim.log

if grep -q "TB FAILED" sim.log; then
  echo "Simulation reported failure"
  exit 1
fi
if ! grep -q "TB PASSED" sim.log; then
  echo "Simulation ended without a result"
  exit 1
fi
echo "Simulation passed"

// ==== sim/tb_fetch_stage.sv ====
// Fetch stage testbench: redirect table, random-latency memory, IF/ID checks
`timescale 1ns/1ps
`include "fetch_settings.svh"

module tb_fetch_stage;

  localparam int          RESET_CYCLES = 8;
  localparam int          NUM_STEPS    = 8;
  localparam int          NUM_EXP      = 15;
  localparam int          NUM_WORDS    = 10;
  localparam logic [31:0] LFSR_SEED    = 32'd84818;
  localparam logic [31:0] DECOY        = 32'h0000_0F00;  // Unselected targets point here

  typedef struct packed {
    fetch_pkg::pc_mux_e mux;
    logic [31:0]        target;  // Redirect address, mtvec base for traps
    logic [4:0]         irq;
    logic [7:0]         start;   // First expected entry
    logic [7:0]         n;       // Instructions to issue
    logic               stall;   // Random id_ready
  } step_t;

  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] instr;   // Expanded form
    logic [15:0] cinstr;  // Low halfword as fetched
    logic        is_c;
    logic        ill;
  } exp_t;

  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] data;
  } mem_init_t;

  logic                      clk;
  logic                      rst_n;
  fetch_pkg::ctrl_fsm_t      ctrl_fsm;
  logic [31:0]               boot_addr, jump_target, branch_target;
  logic [31:0]               mepc, dpc, dm_halt_addr;
  logic [`FETCH_MTVEC_W-1:0] mtvec_addr;
  logic                      mem_req_valid;
  logic                      mem_req_ready;
  fetch_pkg::mem_req_t       mem_req;
  logic                      mem_resp_valid;
  fetch_pkg::mem_resp_t      mem_resp;
  logic                      csr_mtvec_init;
  logic                      if_valid;
  logic                      id_ready;
  logic                      if_busy;
  logic [31:0]               pc_if;
  fetch_pkg::if_id_pipe_t    if_id_pipe;

  step_t                     steps [NUM_STEPS];
  exp_t                      exp_tab [NUM_EXP];
  mem_init_t                 prog [NUM_WORDS];
  logic [31:0]               mem_words [logic [31:0]];  // Sparse instruction memory
  logic [31:0]               req_addr_q [$];            // Accepted, not yet answered
  int unsigned               req_due_q [$];
  int unsigned               cyc;
  logic [31:0]               mem_lfsr;
  logic [31:0]               rdy_lfsr;
  logic [3:0]                mem_bits;
  logic [31:0]               resp_addr;
  int                        exp_ptr;
  int                        errors;
  logic                      load_pending;    // IF/ID loaded at this edge
  logic                      bubble_pending;  // ID ready with nothing issued
  logic                      hold_pending;    // IF/ID valid and stalled
  fetch_pkg::if_id_pipe_t    held_pipe;
  exp_t                      mon_exp;

  fetch_stage UUT (
    .clk              ( clk            ),
    .rst_n            ( rst_n          ),
    .ctrl_fsm_i       ( ctrl_fsm       ),
    .boot_addr_i      ( boot_addr      ),
    .jump_target_i    ( jump_target    ),
    .branch_target_i  ( branch_target  ),
    .mepc_i           ( mepc           ),
    .dpc_i            ( dpc            ),
    .dm_halt_addr_i   ( dm_halt_addr   ),
    .mtvec_addr_i     ( mtvec_addr     ),
    .mem_req_valid_o  ( mem_req_valid  ),
    .mem_req_ready_i  ( mem_req_ready  ),
    .mem_req_o        ( mem_req        ),
    .mem_resp_valid_i ( mem_resp_valid ),
    .mem_resp_i       ( mem_resp       ),
    .csr_mtvec_init_o ( csr_mtvec_init ),
    .if_valid_o       ( if_valid       ),
    .id_ready_i       ( id_ready       ),
    .if_busy_o        ( if_busy        ),
    .pc_if_o          ( pc_if          ),
    .if_id_pipe_o     ( if_id_pipe     )
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  ////////////////////
  // Helpers
  ////////////////////

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  task automatic draw_bits(inout logic [31:0] state, input int n, output logic [3:0] bits);
    int i;
    bits = '0;
    for (i = 0; i < n; i++) begin
      state = lfsr_step(state);
      bits  = {bits[2:0], state[0]};  // One step per bit
    end
  endtask

  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    if (mem_words.exists(addr)) begin
      return mem_words[addr];
    end
    return ~addr ^ 32'h1357_9BDF;  // Fill outside the program
  endfunction

  task automatic report_fail();
    $display("TB FAILED");
    $fatal(1);
  endtask

  task automatic check_val(input string name, input logic [95:0] got, input logic [95:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
      errors++;
      report_fail();
    end
  endtask

  ////////////////////
  // Tables
  ////////////////////

  task automatic load_tables();
    int i;
    prog[0] = '{32'h0000_0100, 32'h0050_0093};  // addi x1,x0,5
    prog[1] = '{32'h0000_0104, 32'h00A0_8113};
    prog[2] = '{32'h0000_0108, 32'h0020_81B3};
    prog[3] = '{32'h0000_0200, 32'h12FD_429D};  // c.addi | c.li
    prog[4] = '{32'h0000_0204, 32'h0393_8316};  // Low half of addi | c.mv
    prog[5] = '{32'h0000_0208, 32'h9396_0033};  // c.add | high half of addi
    prog[6] = '{32'h0000_020C, 32'h8082_4188};  // c.jr | c.lw, both not kept
    prog[7] = '{32'h0000_0210, 32'h5575_A021};  // c.li | c.j
    prog[8] = '{32'h0000_0400, 32'h12FD_429D};
    prog[9] = '{32'h0000_040C, 32'h00B0_0593};
    for (i = 0; i < NUM_WORDS; i++) begin
      mem_words[prog[i].addr] = prog[i].data;
    end
    exp_tab[0]  = '{32'h100, 32'h0050_0093, 16'h0093, 1'b0, 1'b0};
    exp_tab[1]  = '{32'h104, 32'h00A0_8113, 16'h8113, 1'b0, 1'b0};
    exp_tab[2]  = '{32'h108, 32'h0020_81B3, 16'h81B3, 1'b0, 1'b0};
    exp_tab[3]  = '{32'h200, 32'h0070_0293, 16'h429D, 1'b1, 1'b0};  // addi x5,x0,7
    exp_tab[4]  = '{32'h202, 32'hFFF2_8293, 16'h12FD, 1'b1, 1'b0};  // addi x5,x5,-1
    exp_tab[5]  = '{32'h204, 32'h0050_0333, 16'h8316, 1'b1, 1'b0};  // add x6,x0,x5
    exp_tab[6]  = '{32'h206, 32'h0033_0393, 16'h0393, 1'b0, 1'b0};  // Straddles 0x208
    exp_tab[7]  = '{32'h20A, 32'h0053_83B3, 16'h9396, 1'b1, 1'b0};  // add x7,x7,x5
    exp_tab[8]  = '{32'h20C, 32'h0000_4188, 16'h4188, 1'b1, 1'b1};
    exp_tab[9]  = '{32'h20E, 32'h0000_8082, 16'h8082, 1'b1, 1'b1};
    exp_tab[10] = '{32'h210, 32'h0080_006F, 16'hA021, 1'b1, 1'b0};  // jal x0,8
    exp_tab[11] = '{32'h212, 32'hFFD0_0513, 16'h5575, 1'b1, 1'b0};  // addi x10,x0,-3
    exp_tab[12] = '{32'h40C, 32'h00B0_0593, 16'h0593, 1'b0, 1'b0};
    exp_tab[13] = '{32'h400, 32'h0070_0293, 16'h429D, 1'b1, 1'b0};
    exp_tab[14] = '{32'h402, 32'hFFF2_8293, 16'h12FD, 1'b1, 1'b0};
    steps[0] = '{fetch_pkg::BOOT,     32'h100, 5'd0, 8'd0,  8'd3, 1'b0};
    steps[1] = '{fetch_pkg::JUMP,     32'h200, 5'd0, 8'd3,  8'd9, 1'b0};
    steps[2] = '{fetch_pkg::BRANCH,   32'h206, 5'd0, 8'd6,  8'd3, 1'b1};
    steps[3] = '{fetch_pkg::MRET,     32'h104, 5'd0, 8'd1,  8'd2, 1'b1};
    steps[4] = '{fetch_pkg::TRAP_IRQ, 32'h400, 5'd3, 8'd12, 8'd1, 1'b0};
    steps[5] = '{fetch_pkg::TRAP_EXC, 32'h400, 5'd0, 8'd13, 8'd2, 1'b1};
    steps[6] = '{fetch_pkg::DRET,     32'h20C, 5'd0, 8'd8,  8'd3, 1'b0};
    steps[7] = '{fetch_pkg::TRAP_DBG, 32'h102, 5'd0, 8'd0,  8'd2, 1'b1};  // Aligns to 0x100
  endtask

  // Redirect, then let exactly st.n instructions through
  task automatic run_step(input step_t st);
    int         issued;
    logic [3:0] r;
    @(posedge clk);
    boot_addr     <= (st.mux == fetch_pkg::BOOT)     ? st.target : DECOY;
    jump_target   <= (st.mux == fetch_pkg::JUMP)     ? st.target : DECOY;
    branch_target <= (st.mux == fetch_pkg::BRANCH)   ? st.target : DECOY;
    mepc          <= (st.mux == fetch_pkg::MRET)     ? st.target : DECOY;
    dpc           <= (st.mux == fetch_pkg::DRET)     ? st.target : DECOY;
    dm_halt_addr  <= (st.mux == fetch_pkg::TRAP_DBG) ? st.target : DECOY;
    mtvec_addr    <= (st.mux == fetch_pkg::TRAP_EXC || st.mux == fetch_pkg::TRAP_IRQ) ?
                     st.target[31:7] : DECOY[31:7];
    ctrl_fsm.pc_set <= 1'b1;
    ctrl_fsm.pc_mux <= st.mux;
    ctrl_fsm.irq_id <= st.irq;
    exp_ptr = st.start;
    @(posedge clk);
    check_val("csr_mtvec_init_o", csr_mtvec_init, st.mux == fetch_pkg::BOOT);
    ctrl_fsm.pc_set <= 1'b0;
    issued = 0;
    while (issued < st.n) begin
      @(posedge clk);
      if (if_valid && id_ready) begin
        issued++;
      end
      if (issued < st.n) begin
        draw_bits(rdy_lfsr, 1, r);
        id_ready <= st.stall ? r[0] : 1'b1;
      end else begin
        id_ready <= 1'b0;  // Stop before the stream runs past the table
      end
    end
    repeat (2) @(posedge clk);
    // Last issued instruction waits in IF/ID while ID is not ready
    check_val("if_id_pipe_o.instr_valid", if_id_pipe.instr_valid, 1'b1);
    check_val("if_id_pipe_o.pc", if_id_pipe.pc, exp_tab[st.start + st.n - 1].pc);
  endtask

  ////////////////////
  // Sequence
  ////////////////////

  initial begin
    int s;
    rst_n          = 1'b0;
    ctrl_fsm       = '0;
    boot_addr      = DECOY;
    jump_target    = DECOY;
    branch_target  = DECOY;
    mepc           = DECOY;
    dpc            = DECOY;
    dm_halt_addr   = DECOY;
    mtvec_addr     = DECOY[31:7];
    mem_req_ready  = 1'b0;
    mem_resp_valid = 1'b0;
    mem_resp       = '0;
    id_ready       = 1'b0;
    mem_lfsr       = LFSR_SEED;
    rdy_lfsr       = LFSR_SEED;
    cyc            = 0;
    exp_ptr        = 0;
    errors         = 0;
    load_pending   = 1'b0;
    bubble_pending = 1'b0;
    hold_pending   = 1'b0;
    held_pipe      = '0;
    load_tables();
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    repeat (2) @(posedge clk);
    for (s = 0; s < NUM_STEPS; s++) begin
      run_step(steps[s]);
    end
    if (errors == 0) begin
      $display("TB PASSED");
      $finish;
    end else begin
      report_fail();
    end
  end

  // In-order memory, 1 to 4 cycles of latency
  always @(posedge clk) begin
    cyc++;
    if (rst_n) begin
      // Requests not yet consumed by the DUT, including the response on the bus
      check_val("if_busy_o", if_busy, (req_addr_q.size() != 0) || mem_resp_valid);
      if (mem_req_valid && mem_req_ready) begin
        draw_bits(mem_lfsr, 2, mem_bits);
        req_addr_q.push_back(mem_req.addr);
        req_due_q.push_back(cyc + mem_bits[1:0] + 1);
      end
      if (req_addr_q.size() != 0 && req_due_q[0] <= cyc) begin
        resp_addr = req_addr_q.pop_front();
        req_due_q.delete(0);
        mem_resp_valid <= 1'b1;
        mem_resp.rdata <= mem_word(resp_addr);
        mem_resp.err   <= 1'b0;
      end else begin
        mem_resp_valid <= 1'b0;
      end
      draw_bits(mem_lfsr, 2, mem_bits);
      mem_req_ready <= |mem_bits[1:0];  // Ready three times in four
    end
  end

  ////////////////////
  // Monitor
  ////////////////////

  always @(posedge clk) begin
    if (rst_n) begin
      if (load_pending) begin
        mon_exp = exp_tab[exp_ptr];
        check_val("if_id_pipe_o.instr_valid", if_id_pipe.instr_valid, 1'b1);
        check_val("if_id_pipe_o.pc", if_id_pipe.pc, mon_exp.pc);
        check_val("if_id_pipe_o.instr", if_id_pipe.instr, mon_exp.instr);
        check_val("if_id_pipe_o.compressed_instr", if_id_pipe.compressed_instr, mon_exp.cinstr);
        check_val("if_id_pipe_o.is_compressed", if_id_pipe.is_compressed, mon_exp.is_c);
        check_val("if_id_pipe_o.illegal_c", if_id_pipe.illegal_c, mon_exp.ill);
        check_val("if_id_pipe_o.bus_err", if_id_pipe.bus_err, 1'b0);
        exp_ptr++;
      end
      if (bubble_pending) begin
        check_val("if_id_pipe_o.instr_valid", if_id_pipe.instr_valid, 1'b0);  // Bubble into ID
      end
      if (hold_pending) begin
        check_val("if_id_pipe_o", if_id_pipe, held_pipe);  // Stalled ID sees no change
      end
      if (if_valid && id_ready) begin
        check_val("pc_if_o", pc_if, exp_tab[exp_ptr].pc);  // PC of the instruction issued now
      end
      if (!ctrl_fsm.pc_set) begin
        check_val("csr_mtvec_init_o", csr_mtvec_init, 1'b0);
      end
    end
    load_pending   <= rst_n && if_valid && id_ready;
    bubble_pending <= rst_n && id_ready && !if_valid;
    hold_pending   <= rst_n && if_id_pipe.instr_valid && !id_ready;
    held_pipe      <= if_id_pipe;
  end

  // Each step needs far fewer than 64 cycles
  initial begin
    repeat (RESET_CYCLES + NUM_STEPS * 64) @(posedge clk);
    $display("Timeout, the fetch stage stopped issuing instructions");
    report_fail();
  end

endmodule
